/* src/stq_pkg.sv */
package stq_pkg;

////////////////////////////////////////////////////////////////////////////
// Widths with a meaning
////////////////////////////////////////////////////////////////////////////

typedef logic [5:0]  t_rob_id;   // Compared modulo 64 against oldest
typedef logic [3:0]  t_stq_id;   // Up to 16 queue entries
typedef logic [31:0] t_addr;     // Byte address
typedef logic [31:0] t_data;
typedef logic [1:0]  t_opsize;   // Passed through to done

////////////////////////////////////////////////////////////////////////////
// Encodings
////////////////////////////////////////////////////////////////////////////

// Result of a store at mm5
typedef enum logic {
    ACT_COMPLETE,
    ACT_REPLAY
} t_pipe_action;

// Entry lifetime
typedef enum logic [1:0] {
    ST_FREE,
    ST_WAIT_ISS,   // Dispatched, no address yet
    ST_READY,      // Requesting the pipe
    ST_IN_PIPE
} t_stq_state;

endpackage

/* src/mempipe_if.sv */
`timescale 1ns/1ns

interface mempipe_if
    import stq_pkg::*;
();

// Request side, mm0
logic         req;
t_stq_id      req_stqid;
t_rob_id      req_robid;
t_addr        req_addr;
logic         gnt;

// Result side, one cycle strobe
logic         valid_mm5;
t_stq_id      stqid_mm5;
t_rob_id      robid_mm5;
t_pipe_action action_mm5;

modport queue (
    output req, req_stqid, req_robid, req_addr,
    input  gnt, valid_mm5, stqid_mm5, robid_mm5, action_mm5
);

modport pipe (
    input  req, req_stqid, req_robid, req_addr,
    output gnt, valid_mm5, stqid_mm5, robid_mm5, action_mm5
);

endinterface

/* src/age_matrix.sv */
`timescale 1ns/1ns

module age_matrix #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_ENTRIES-1:0] alloc,    // One-hot
    input  logic [NUM_ENTRIES-1:0] valid,
    input  logic [NUM_ENTRIES-1:0] reqs,
    output logic [NUM_ENTRIES-1:0] oldest    // One-hot
);

// Row i has bit j set when entry j is older than entry i
logic [NUM_ENTRIES-1:0] elders [NUM_ENTRIES];

////////////////////////////////////////////////////////////////////////////
// Matrix update
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            elders[i] <= '0;
        end
    end else begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (alloc[i]) begin
                elders[i] <= valid;              // Everyone live is older
            end else begin
                elders[i] <= elders[i] & valid;  // Drop freed columns
            end
        end
    end
end

////////////////////////////////////////////////////////////////////////////
// Oldest requester
////////////////////////////////////////////////////////////////////////////

always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        oldest[i] = reqs[i] & ~|(elders[i] & reqs);
    end
end

endmodule

/* src/storeq_entry.sv */
`timescale 1ns/1ns

module storeq_entry
    import stq_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  t_stq_id      id,

    input  t_rob_id      oldest_robid,
    input  logic         nuke_valid,
    input  t_rob_id      nuke_robid,

    input  logic         alloc,
    input  t_rob_id      alloc_robid,
    input  t_opsize      alloc_opsize,

    input  logic         iss_valid,
    input  t_stq_id      iss_stqid,
    input  t_addr        iss_addr,
    input  t_data        iss_data,

    input  logic         gnt,
    input  logic         pipe_valid_mm5,
    input  t_stq_id      pipe_stqid_mm5,
    input  t_rob_id      pipe_robid_mm5,
    input  t_pipe_action pipe_action_mm5,

    output logic         valid,
    output logic         req,
    output t_rob_id      robid,
    output t_addr        addr,
    output t_data        data,
    output t_opsize      opsize,
    output logic         done
);

t_stq_state state;
t_stq_state state_nxt;

t_rob_id    age;         // Distance from oldest
t_rob_id    nuke_age;
logic       nuke_hit;
logic       iss_hit;
logic       mm5_hit;

////////////////////////////////////////////////////////////////////////////
// Event decode
////////////////////////////////////////////////////////////////////////////

assign age      = robid - oldest_robid;        // Wraps mod 64
assign nuke_age = nuke_robid - oldest_robid;
assign nuke_hit = nuke_valid && valid && (age >= nuke_age);

assign iss_hit  = iss_valid && (iss_stqid == id) && (state == ST_WAIT_ISS);

// A result is ours only if the slot still holds the same store
assign mm5_hit  = pipe_valid_mm5 && (state == ST_IN_PIPE) &&
                  (pipe_stqid_mm5 == id) && (pipe_robid_mm5 == robid);

assign done     = mm5_hit && (pipe_action_mm5 == ACT_COMPLETE) && !nuke_hit;

assign valid    = (state != ST_FREE);
assign req      = (state == ST_READY);

////////////////////////////////////////////////////////////////////////////
// State machine
////////////////////////////////////////////////////////////////////////////

always_comb begin
    state_nxt = state;
    case (state)
        ST_FREE: begin
            if (alloc) begin
                state_nxt = ST_WAIT_ISS;
            end
        end
        ST_WAIT_ISS: begin
            if (iss_hit) begin
                state_nxt = ST_READY;
            end
        end
        ST_READY: begin
            if (gnt) begin
                state_nxt = ST_IN_PIPE;
            end
        end
        ST_IN_PIPE: begin
            if (mm5_hit) begin
                state_nxt = (pipe_action_mm5 == ACT_COMPLETE) ? ST_FREE : ST_READY;
            end
        end
        default: state_nxt = ST_FREE;
    endcase
    if (nuke_hit) begin
        state_nxt = ST_FREE;   // Nuke beats everything
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= ST_FREE;
    end else begin
        state <= state_nxt;
    end
end

////////////////////////////////////////////////////////////////////////////
// Payload
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (alloc && (state == ST_FREE)) begin
        robid  <= alloc_robid;
        opsize <= alloc_opsize;
    end
    if (iss_hit) begin
        addr <= iss_addr;
        data <= iss_data;
    end
end

endmodule

/* src/storeq.sv */
`timescale 1ns/1ns

module storeq
    import stq_pkg::*;
#(
    parameter int NUM_ENTRIES = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  t_rob_id   oldest_robid,
    input  logic      nuke_valid,
    input  t_rob_id   nuke_robid,

    input  logic      disp_valid,
    input  t_rob_id   disp_robid,
    input  t_opsize   disp_opsize,
    output t_stq_id   stqid_alloc,

    input  logic      iss_valid,
    input  t_stq_id   iss_stqid,
    input  t_addr     iss_addr,
    input  t_data     iss_data,

    output logic      done_valid,
    output t_rob_id   done_robid,
    output t_addr     done_addr,
    output t_data     done_data,
    output t_opsize   done_opsize,
    output logic      idle,
    output logic      full,

    mempipe_if.queue  pipe
);

logic [NUM_ENTRIES-1:0] e_valid;
logic [NUM_ENTRIES-1:0] e_req;
logic [NUM_ENTRIES-1:0] e_done;
logic [NUM_ENTRIES-1:0] e_gnt;
logic [NUM_ENTRIES-1:0] e_alloc;
logic [NUM_ENTRIES-1:0] e_alloc_sel;   // Lowest free, one-hot
logic [NUM_ENTRIES-1:0] e_oldest;

t_rob_id e_robid  [NUM_ENTRIES];
t_addr   e_addr   [NUM_ENTRIES];
t_data   e_data   [NUM_ENTRIES];
t_opsize e_opsize [NUM_ENTRIES];

////////////////////////////////////////////////////////////////////////////
// Allocation
////////////////////////////////////////////////////////////////////////////

always_comb begin
    e_alloc_sel = '0;
    stqid_alloc = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
        if (!e_valid[i]) begin
            e_alloc_sel = '0;
            e_alloc_sel[i] = 1'b1;
            stqid_alloc = t_stq_id'(i);
        end
    end
end

assign e_alloc = disp_valid ? e_alloc_sel : '0;

assign idle = ~|e_valid;
assign full = &e_valid;

age_matrix #(.NUM_ENTRIES(NUM_ENTRIES)) age_mtx (
    .clk,
    .rst,
    .alloc  ( e_alloc  ),
    .valid  ( e_valid  ),
    .reqs   ( e_req    ),
    .oldest ( e_oldest )
);

////////////////////////////////////////////////////////////////////////////
// Entries
////////////////////////////////////////////////////////////////////////////

for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entries
    storeq_entry entry (
        .clk,
        .rst,
        .id              ( t_stq_id'(e)    ),
        .oldest_robid,
        .nuke_valid,
        .nuke_robid,
        .alloc           ( e_alloc[e]      ),
        .alloc_robid     ( disp_robid      ),
        .alloc_opsize    ( disp_opsize     ),
        .iss_valid,
        .iss_stqid,
        .iss_addr,
        .iss_data,
        .gnt             ( e_gnt[e]        ),
        .pipe_valid_mm5  ( pipe.valid_mm5  ),
        .pipe_stqid_mm5  ( pipe.stqid_mm5  ),
        .pipe_robid_mm5  ( pipe.robid_mm5  ),
        .pipe_action_mm5 ( pipe.action_mm5 ),
        .valid           ( e_valid[e]      ),
        .req             ( e_req[e]        ),
        .robid           ( e_robid[e]      ),
        .addr            ( e_addr[e]       ),
        .data            ( e_data[e]       ),
        .opsize          ( e_opsize[e]     ),
        .done            ( e_done[e]       )
    );
end

////////////////////////////////////////////////////////////////////////////
// Pipe request, oldest first
////////////////////////////////////////////////////////////////////////////

always_comb begin
    pipe.req_stqid = '0;
    pipe.req_robid = '0;
    pipe.req_addr  = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (e_oldest[i]) begin
            pipe.req_stqid = pipe.req_stqid | t_stq_id'(i);
            pipe.req_robid = pipe.req_robid | e_robid[i];
            pipe.req_addr  = pipe.req_addr  | e_addr[i];
        end
    end
end

assign pipe.req = |e_req;
assign e_gnt    = pipe.gnt ? e_oldest : '0;

////////////////////////////////////////////////////////////////////////////
// Done report
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        done_valid <= 1'b0;
    end else begin
        done_valid <= |e_done;   // At most one per cycle
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (e_done[i]) begin
            done_robid  <= e_robid[i];
            done_addr   <= e_addr[i];
            done_data   <= e_data[i];
            done_opsize <= e_opsize[i];
        end
    end
end

endmodule

/* src/mem_pipe.sv */
`timescale 1ns/1ns

module mem_pipe
    import stq_pkg::*;
#(
    parameter int TAG_LINES = 64
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     pipe_stall,
    mempipe_if.pipe  pipe
);

localparam int IDX_W = $clog2(TAG_LINES);
localparam int TAG_W = 32 - 4 - IDX_W;    // Above line offset and index

logic                  accept;
logic [4:0]            stg_valid;         // mm1 at bit 0, mm5 at bit 4
t_stq_id               stg_stqid [5];
t_rob_id               stg_robid [5];
t_addr                 stg_addr  [5];

logic [TAG_LINES-1:0]  line_valid;
logic [TAG_W-1:0]      line_tag [TAG_LINES];
logic [IDX_W-1:0]      idx_mm5;
logic [TAG_W-1:0]      tag_mm5;
logic                  hit_mm5;

////////////////////////////////////////////////////////////////////////////
// Grant and stages
////////////////////////////////////////////////////////////////////////////

assign pipe.gnt = !pipe_stall;
assign accept   = pipe.req && pipe.gnt;

always_ff @(posedge clk) begin
    if (rst) begin
        stg_valid <= '0;
    end else begin
        stg_valid <= {stg_valid[3:0], accept};
    end
end

always_ff @(posedge clk) begin
    stg_stqid[0] <= pipe.req_stqid;
    stg_robid[0] <= pipe.req_robid;
    stg_addr[0]  <= pipe.req_addr;
    for (int s = 1; s < 5; s++) begin
        stg_stqid[s] <= stg_stqid[s-1];
        stg_robid[s] <= stg_robid[s-1];
        stg_addr[s]  <= stg_addr[s-1];
    end
end

////////////////////////////////////////////////////////////////////////////
// Tag lookup at mm5
////////////////////////////////////////////////////////////////////////////

assign idx_mm5 = stg_addr[4][4 +: IDX_W];
assign tag_mm5 = stg_addr[4][31 -: TAG_W];
assign hit_mm5 = line_valid[idx_mm5] && (line_tag[idx_mm5] == tag_mm5);

assign pipe.valid_mm5  = stg_valid[4];
assign pipe.stqid_mm5  = stg_stqid[4];
assign pipe.robid_mm5  = stg_robid[4];
assign pipe.action_mm5 = hit_mm5 ? ACT_COMPLETE : ACT_REPLAY;

// Fill on miss so the replay hits
always_ff @(posedge clk) begin
    if (rst) begin
        line_valid <= '0;
    end else if (stg_valid[4] && !hit_mm5) begin
        line_valid[idx_mm5] <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (stg_valid[4] && !hit_mm5) begin
        line_tag[idx_mm5] <= tag_mm5;
    end
end

endmodule

/* src/storeq_top.sv */
`timescale 1ns/1ns

module storeq_top
    import stq_pkg::*;
#(
    parameter int NUM_ENTRIES = 8,
    parameter int TAG_LINES   = 64
) (
    input  logic    clk,
    input  logic    rst,
    input  t_rob_id oldest_robid,
    input  logic    nuke_valid,
    input  t_rob_id nuke_robid,

    input  logic    disp_valid,
    input  t_rob_id disp_robid,
    input  t_opsize disp_opsize,
    output t_stq_id stqid_alloc,

    input  logic    iss_valid,
    input  t_stq_id iss_stqid,
    input  t_addr   iss_addr,
    input  t_data   iss_data,

    input  logic    pipe_stall,

    output logic    done_valid,
    output t_rob_id done_robid,
    output t_addr   done_addr,
    output t_data   done_data,
    output t_opsize done_opsize,
    output logic    idle,
    output logic    full
);

mempipe_if pipe_bus ();   // Queue to pipe

storeq #(.NUM_ENTRIES(NUM_ENTRIES)) stq (
    .clk,
    .rst,
    .oldest_robid,
    .nuke_valid,
    .nuke_robid,
    .disp_valid,
    .disp_robid,
    .disp_opsize,
    .stqid_alloc,
    .iss_valid,
    .iss_stqid,
    .iss_addr,
    .iss_data,
    .done_valid,
    .done_robid,
    .done_addr,
    .done_data,
    .done_opsize,
    .idle,
    .full,
    .pipe ( pipe_bus.queue )
);

mem_pipe #(.TAG_LINES(TAG_LINES)) mpipe (
    .clk,
    .rst,
    .pipe_stall,
    .pipe ( pipe_bus.pipe )
);

endmodule

/* tests/storeq_tb.sv */
`timescale 1ns/1ns

module storeq_tb
    import stq_pkg::*;
();

localparam int NUM_ENTRIES = 8;
localparam int MAX_CYCLES  = 1500;   // About three times the full run

logic    clk = 1'b0;
logic    rst;
t_rob_id oldest_robid;
logic    nuke_valid;
t_rob_id nuke_robid;
logic    disp_valid;
t_rob_id disp_robid;
t_opsize disp_opsize;
t_stq_id stqid_alloc;
logic    iss_valid;
t_stq_id iss_stqid;
t_addr   iss_addr;
t_data   iss_data;
logic    pipe_stall;
logic    done_valid;
t_rob_id done_robid;
t_addr   done_addr;
t_data   done_data;
t_opsize done_opsize;
logic    idle;
logic    full;

int          cycle = 0;
int          errors = 0;
int          failed_tests = 0;
int          done_count = 0;
int          seq = 0;
logic [31:0] seed = 32'he466_fec2;
logic        check_lat = 1'b0;
t_rob_id     next_robid = '0;

// Expected queue contents, by entry id
logic    exp_live      [16];
logic    exp_issued    [16];
t_rob_id exp_robid     [16];
t_addr   exp_addr      [16];
t_data   exp_data      [16];
t_opsize exp_opsize    [16];
int      exp_seq       [16];
int      exp_iss_cycle [16];
int      exp_lat       [16];   // Zero when not timed

logic [63:0] tag_valid;
logic [21:0] tag_line [64];
t_rob_id     done_order [$];
int          done_cycles [$];

storeq_top DUT (.*);

always #50 clk = ~clk;

always @(posedge clk) begin
    cycle++;
    if (cycle > MAX_CYCLES) begin
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end
end

////////////////////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] xorshift32();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
endfunction

task automatic log_error(string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
endtask

function automatic int live_count();
    int n;
    n = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (exp_live[i]) begin
            n++;
        end
    end
    return n;
endfunction

function automatic int pick_waiting(int start);
    int j;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        j = (start + i) % NUM_ENTRIES;
        if (exp_live[j] && !exp_issued[j]) begin
            return j;
        end
    end
    return -1;
endfunction

function automatic t_addr line_addr(int idx);
    logic [31:0] r;
    r = xorshift32();
    return {r[31:10], 6'(idx), r[3:0]};
endfunction

function automatic logic model_hit(t_addr a);
    return tag_valid[a[9:4]] && (tag_line[a[9:4]] == a[31:10]);
endfunction

////////////////////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////////////////////

task automatic dispatch(output t_stq_id id);
    logic [31:0] rnd;
    int          want;
    rnd = xorshift32();
    @(negedge clk);
    disp_valid  = 1'b1;
    disp_robid  = next_robid;
    disp_opsize = rnd[1:0];
    #1;
    want = -1;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
        if (!exp_live[i]) begin
            want = i;   // Lowest free
        end
    end
    id = stqid_alloc;
    assert (id == t_stq_id'(want))
        else log_error($sformatf("allocated id %0d, expected %0d", id, want));
    @(negedge clk);
    exp_live[id]   = 1'b1;
    exp_issued[id] = 1'b0;
    exp_robid[id]  = next_robid;
    exp_opsize[id] = rnd[1:0];
    exp_seq[id]    = seq;
    seq++;
    next_robid++;
    disp_valid = 1'b0;
endtask

task automatic issue(t_stq_id id, t_addr addr);
    t_data d;
    d = xorshift32();
    @(negedge clk);
    iss_valid = 1'b1;
    iss_stqid = id;
    iss_addr  = addr;
    iss_data  = d;
    exp_issued[id]    = 1'b1;
    exp_addr[id]      = addr;
    exp_data[id]      = d;
    exp_iss_cycle[id] = cycle;
    exp_lat[id]       = check_lat ? (model_hit(addr) ? 7 : 13) : 0;
    tag_valid[addr[9:4]] = 1'b1;
    tag_line[addr[9:4]]  = addr[31:10];
    @(negedge clk);
    iss_valid = 1'b0;
endtask

task automatic nuke(t_rob_id target);
    int      oldest_seq;
    t_rob_id old;
    oldest_seq = seq;
    old = next_robid;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (exp_live[i] && exp_seq[i] < oldest_seq) begin
            oldest_seq = exp_seq[i];
            old = exp_robid[i];
        end
    end
    @(negedge clk);
    oldest_robid = old;
    nuke_robid   = target;
    nuke_valid   = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (exp_live[i] && t_rob_id'(exp_robid[i] - old) >= t_rob_id'(target - old)) begin
            exp_live[i] = 1'b0;
        end
    end
    nuke_valid = 1'b0;
endtask

task automatic wait_dones(int n);
    int target;
    target = done_count + n;
    while (done_count < target) begin
        @(negedge clk);
        #3;
    end
endtask

task automatic drain();
    do begin
        @(negedge clk);
        #3;
    end while (!idle || live_count() != 0);
endtask

task automatic report_test(string name, int errs_before);
    if (errors == errs_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, errors - errs_before);
        failed_tests++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Done and status checks
////////////////////////////////////////////////////////////////////////////

always @(negedge clk) begin
    int k;
    if (!rst && done_valid) begin
        k = -1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (exp_live[i] && exp_robid[i] == done_robid) begin
                k = i;
            end
        end
        assert (k >= 0)
            else log_error($sformatf("done for robid %0d, no live store", done_robid));
        if (k >= 0) begin
            assert (exp_issued[k] && done_addr == exp_addr[k] && done_data == exp_data[k]
                    && done_opsize == exp_opsize[k])
                else log_error($sformatf("done fields wrong for robid %0d", done_robid));
            assert (exp_lat[k] == 0 || cycle - exp_iss_cycle[k] == exp_lat[k])
                else log_error($sformatf("done latency %0d, expected %0d",
                                         cycle - exp_iss_cycle[k], exp_lat[k]));
            exp_live[k] = 1'b0;
            done_order.push_back(done_robid);
            done_cycles.push_back(cycle);
            done_count++;
        end
    end
    #2;   // After the tasks' own updates
    if (!rst) begin
        assert (idle == (live_count() == 0))
            else log_error($sformatf("idle %0b with %0d live", idle, live_count()));
        assert (full == (live_count() == NUM_ENTRIES))
            else log_error($sformatf("full %0b with %0d live", full, live_count()));
    end
end

////////////////////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////////////////////

initial begin
    t_stq_id     ids  [NUM_ENTRIES];
    t_rob_id     robs [NUM_ENTRIES];
    t_addr       warm [4];
    t_stq_id     id;
    t_addr       a;
    logic [31:0] rnd;
    int          e0;
    int          base;
    int          w;
    rst = 1'b1;
    oldest_robid = '0;
    nuke_valid   = 1'b0;
    nuke_robid   = '0;
    disp_valid   = 1'b0;
    disp_robid   = '0;
    disp_opsize  = '0;
    iss_valid    = 1'b0;
    iss_stqid    = '0;
    iss_addr     = '0;
    iss_data     = '0;
    pipe_stall   = 1'b0;
    tag_valid    = '0;
    for (int i = 0; i < 16; i++) begin
        exp_live[i] = 1'b0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    e0 = errors;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        dispatch(ids[i]);
        assert (ids[i] == t_stq_id'(i))
            else log_error($sformatf("dispatch %0d got %0d", i, ids[i]));
    end
    assert (full) else log_error("full low with every entry dispatched");
    check_lat = 1'b1;
    issue(ids[3], line_addr(3));
    wait_dones(1);
    dispatch(id);
    assert (id == ids[3]) else log_error($sformatf("freed entry 3 not reused, got %0d", id));
    check_lat = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        issue(t_stq_id'(i), line_addr(i));
    end
    drain();
    report_test("allocation and status", e0);

    e0 = errors;
    check_lat = 1'b1;
    dispatch(id);
    a = line_addr(40);
    issue(id, a);
    drain();
    report_test("miss then replay", e0);

    e0 = errors;
    dispatch(id);
    rnd = xorshift32();
    issue(id, {a[31:4], rnd[3:0]});   // Same line, now filled
    drain();
    check_lat = 1'b0;
    report_test("hit", e0);

    e0 = errors;
    for (int i = 0; i < 4; i++) begin
        dispatch(ids[i]);
        warm[i] = line_addr(48 + i);
        issue(ids[i], warm[i]);
    end
    drain();
    base = done_count;
    pipe_stall = 1'b1;
    for (int i = 0; i < 4; i++) begin
        dispatch(ids[i]);
        robs[i] = exp_robid[ids[i]];
    end
    for (int i = 3; i >= 0; i--) begin
        rnd = xorshift32();
        issue(ids[i], {warm[i][31:4], rnd[3:0]});
    end
    repeat (10) @(negedge clk);
    assert (done_count == base) else log_error("done reported while the pipe was stalled");
    done_order.delete();
    done_cycles.delete();
    pipe_stall = 1'b0;
    drain();
    assert (done_order.size() == 4) else log_error("stalled stores did not all complete");
    for (int i = 0; i < 4; i++) begin
        assert (done_order[i] == robs[i])
            else log_error($sformatf("done %0d robid %0d, expected %0d", i, done_order[i], robs[i]));
        if (i > 0) begin
            assert (done_cycles[i] == done_cycles[i-1] + 1)
                else log_error($sformatf("done %0d not in the cycle after the previous", i));
        end
    end
    report_test("oldest first under stall", e0);

    e0 = errors;
    for (int i = 0; i < 6; i++) begin
        dispatch(ids[i]);
        robs[i] = exp_robid[ids[i]];
    end
    done_order.delete();
    for (int i = 0; i < 5; i++) begin
        if (i != 2) begin
            issue(ids[i], line_addr(20 + i));   // Cold lines keep them in the pipe
        end
    end
    nuke(robs[2]);
    drain();
    assert (done_order.size() == 2 && done_order[0] == robs[0] && done_order[1] == robs[1])
        else log_error($sformatf("%0d dones after nuke, expected the 2 older stores",
                                 done_order.size()));
    report_test("nuke", e0);

    e0 = errors;
    for (int n = 0; n < 80; n++) begin
        rnd = xorshift32();
        pipe_stall = (rnd[7:5] == 3'd0);
        w = pick_waiting(int'(rnd[15:12]));
        if (rnd[1:0] != 2'd0 && !full) begin
            dispatch(id);
        end else if (rnd[20:16] == 5'd0 && w >= 0) begin
            nuke(exp_robid[w]);
        end else if (w >= 0) begin
            issue(t_stq_id'(w), xorshift32());
        end else begin
            @(negedge clk);
        end
    end
    pipe_stall = 1'b0;
    w = pick_waiting(0);
    while (w >= 0) begin
        issue(t_stq_id'(w), xorshift32());
        w = pick_waiting(0);
    end
    drain();
    report_test("random mix", e0);

    $display("tests: 6, failed: %0d, errors: %0d", failed_tests, errors);
    if (errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

/* vlog.f */
src/stq_pkg.sv
src/mempipe_if.sv
src/age_matrix.sv
src/storeq_entry.sv
src/storeq.sv
src/mem_pipe.sv
src/storeq_top.sv
tests/storeq_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f \
    --top-module storeq_tb -o storeq_sim \
    && ./obj_dir/storeq_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"
